// File: aes_pkg.sv
package aes_pkg;

	localparam int block_bits = 128;
	localparam int key_bits = 256;
	localparam int max_round_keys = 15;
	localparam int round_addr_bits = 4;

	localparam logic [round_addr_bits-1:0] rounds_128 = 4'd10;
	localparam logic [round_addr_bits-1:0] rounds_256 = 4'd14;

	localparam logic [7:0] rcon_table [10] = '{
		8'h01, 8'h02, 8'h04, 8'h08, 8'h10, 8'h20, 8'h40, 8'h80, 8'h1b, 8'h36
	};

	// Forward S-box, entry 0 in the top byte.
	localparam logic [2047:0] sbox_table = {
		128'h637c777bf26b6fc53001672bfed7ab76,
		128'hca82c97dfa5947f0add4a2af9ca472c0,
		128'hb7fd9326363ff7cc34a5e5f171d83115,
		128'h04c723c31896059a071280e2eb27b275,
		128'h09832c1a1b6e5aa0523bd6b329e32f84,
		128'h53d100ed20fcb15b6acbbe394a4c58cf,
		128'hd0efaafb434d338545f9027f503c9fa8,
		128'h51a3408f929d38f5bcb6da2110fff3d2,
		128'hcd0c13ec5f974417c4a77e3d645d1973,
		128'h60814fdc222a908846eeb814de5e0bdb,
		128'he0323a0a4906245cc2d3ac629195e479,
		128'he7c8376d8dd54ea96c56f4ea657aae08,
		128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
		128'h703eb5664803f60e613557b986c11d9e,
		128'he1f8981169d98e949b1e87e9ce5528df,
		128'h8ca1890dbfe6426841992d0fb054bb16
	};

	function automatic logic [7:0] sbox(input logic [7:0] b);
		return sbox_table[(255 - int'(b)) * 8 +: 8];
	endfunction

	function automatic logic [31:0] sub_word(input logic [31:0] w);
		logic [31:0] r;
		for (int i = 0; i < 4; i++)
			r[8*i +: 8] = sbox(w[8*i +: 8]);
		return r;
	endfunction

	// Byte 0 of a word is its top byte, so this moves it to the bottom.
	function automatic logic [31:0] rot_word(input logic [31:0] w);
		return {w[23:0], w[31:24]};
	endfunction

	// The state is column major with byte 0 in the top eight bits.
	function automatic logic [block_bits-1:0] shift_rows(input logic [block_bits-1:0] s);
		logic [block_bits-1:0] r;
		for (int c = 0; c < 4; c++)
			for (int row = 0; row < 4; row++)
				r[127 - 8*(4*c + row) -: 8] = s[127 - 8*(4*((c + row) % 4) + row) -: 8];
		return r;
	endfunction

	function automatic logic [7:0] xtime(input logic [7:0] b);
		return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
	endfunction

	function automatic logic [block_bits-1:0] mix_columns(input logic [block_bits-1:0] s);
		logic [block_bits-1:0] r;
		logic [31:0] col;
		logic [7:0] a0, a1, a2, a3;
		for (int c = 0; c < 4; c++) begin
			col = s[127 - 32*c -: 32];
			a0 = col[31:24];
			a1 = col[23:16];
			a2 = col[15:8];
			a3 = col[7:0];
			r[127 - 32*c -: 32] = {
				xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
				a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
				a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
				xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)
			};
		end
		return r;
	endfunction

endpackage

// File: round_key_mem.sv
module round_key_mem (
	input  logic                                clk,
	input  logic                                wr_en,
	input  logic [aes_pkg::round_addr_bits-1:0] wr_addr,
	input  logic [aes_pkg::block_bits-1:0]      wr_data,
	input  logic [aes_pkg::round_addr_bits-1:0] rd_addr,
	output logic [aes_pkg::block_bits-1:0]      rd_data
);

	logic [aes_pkg::block_bits-1:0] mem [aes_pkg::max_round_keys];

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// The cipher sees the key for its current round in the same cycle.
	assign rd_data = mem[rd_addr];

	assert property (@(posedge clk)
		wr_en |-> wr_addr < aes_pkg::max_round_keys);

endmodule

// File: round_key.sv
// Round key 0 comes from key[127:0]; in AES-256 mode round key 1 comes from key[255:128].
module round_key (
	input  logic                                clk,
	input  logic                                reset,
	input  logic                                key_load,
	input  logic                                key_256,
	input  logic [aes_pkg::key_bits-1:0]        key,
	output logic                                key_wr_en,
	output logic [aes_pkg::round_addr_bits-1:0] key_wr_addr,
	output logic [aes_pkg::block_bits-1:0]      key_wr_data,
	output logic                                keys_done
);

	logic                                mode_256;
	logic                                active;
	logic [aes_pkg::round_addr_bits-1:0] step;
	logic [aes_pkg::round_addr_bits-1:0] rcon_idx;
	logic [aes_pkg::round_addr_bits-1:0] last_step;
	logic [aes_pkg::key_bits-1:0]        key_reg;
	logic [aes_pkg::key_bits-1:0]        prev;
	logic                                use_rcon;
	logic [31:0]                         g_in;
	logic [31:0]                         g_word;
	logic [31:0]                         w0;
	logic [31:0]                         w1;
	logic [31:0]                         w2;
	logic [31:0]                         w3;
	logic [aes_pkg::block_bits-1:0]      next_key;

	assign last_step = mode_256 ? aes_pkg::rounds_256 : aes_pkg::rounds_128;

	// In AES-256 mode the even steps take the full g path and the odd ones only substitute.
	assign use_rcon = mode_256 ? (step >= 4'd2 && !step[0]) : (step >= 4'd1);

	// The upper half of prev holds the newest key, the lower half the one before.
	assign g_in = prev[aes_pkg::block_bits +: 32];

	always_comb begin
		if (use_rcon)
			g_word = aes_pkg::sub_word(aes_pkg::rot_word(g_in))
				^ {aes_pkg::rcon_table[rcon_idx], 24'h000000};
		else
			g_word = aes_pkg::sub_word(g_in);
		w0 = prev[127:96] ^ g_word;
		w1 = prev[95:64] ^ w0;
		w2 = prev[63:32] ^ w1;
		w3 = prev[31:0] ^ w2;
		if (step == 4'd0)
			next_key = key_reg[aes_pkg::block_bits-1:0];
		else if (mode_256 && step == 4'd1)
			next_key = key_reg[aes_pkg::key_bits-1:aes_pkg::block_bits];
		else
			next_key = {w0, w1, w2, w3};
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			mode_256 <= 1'b0;
			active <= 1'b0;
			step <= '0;
			rcon_idx <= '0;
			key_wr_en <= 1'b0;
			key_wr_addr <= '0;
			keys_done <= 1'b0;
		end else begin
			key_wr_en <= active && !key_load;
			keys_done <= active && !key_load && step == last_step;
			if (key_load) begin
				mode_256 <= key_256;
				active <= 1'b1;
				step <= '0;
				rcon_idx <= '0;
			end else if (active) begin
				key_wr_addr <= step;
				step <= step + 4'd1;
				if (use_rcon)
					rcon_idx <= rcon_idx + 4'd1;
				if (step == last_step)
					active <= 1'b0;
			end
		end
	end

	// For AES-128 both halves of prev carry the newest key, so the same word path serves both.
	always_ff @(posedge clk) begin
		if (key_load)
			key_reg <= key;
		if (active) begin
			key_wr_data <= next_key;
			if (mode_256)
				prev <= {next_key, prev[aes_pkg::key_bits-1:aes_pkg::block_bits]};
			else
				prev <= {next_key, next_key};
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		key_wr_en |-> key_wr_addr <= last_step);

	assert property (@(posedge clk) disable iff (reset)
		keys_done |-> key_wr_en && key_wr_addr == last_step);

endmodule

// File: aes_cipher.sv
module aes_cipher (
	input  logic                                clk,
	input  logic                                reset,
	input  logic                                key_load,
	input  logic                                key_256,
	input  logic                                keys_done,
	input  logic                                block_start,
	input  logic [aes_pkg::block_bits-1:0]      block_in,
	input  logic [aes_pkg::block_bits-1:0]      key_rd_data,
	output logic [aes_pkg::round_addr_bits-1:0] key_rd_addr,
	output logic                                key_ready,
	output logic                                block_done,
	output logic [aes_pkg::block_bits-1:0]      block_out
);

	logic [aes_pkg::round_addr_bits-1:0] rounds;
	logic [aes_pkg::round_addr_bits-1:0] round;
	logic                                busy;
	logic                                start_ok;
	logic                                final_round;
	logic [aes_pkg::block_bits-1:0]      state;
	logic [aes_pkg::block_bits-1:0]      sub_state;
	logic [aes_pkg::block_bits-1:0]      shifted;
	logic [aes_pkg::block_bits-1:0]      mixed;
	logic [aes_pkg::block_bits-1:0]      next_state;

	assign start_ok = block_start && key_ready && !busy;

	// The round counter is zero while idle, so key 0 is on the read port for a start.
	assign key_rd_addr = round;
	assign final_round = (round == rounds);

	always_comb begin
		for (int i = 0; i < 16; i++)
			sub_state[8*i +: 8] = aes_pkg::sbox(state[8*i +: 8]);
	end

	assign shifted = aes_pkg::shift_rows(sub_state);
	assign mixed = aes_pkg::mix_columns(shifted);

	// The last round has no mix columns step.
	assign next_state = (final_round ? shifted : mixed) ^ key_rd_data;

	always_ff @(posedge clk) begin
		if (reset) begin
			rounds <= aes_pkg::rounds_128;
			key_ready <= 1'b0;
			busy <= 1'b0;
			round <= '0;
			block_done <= 1'b0;
		end else begin
			block_done <= 1'b0;
			if (key_load) begin
				key_ready <= 1'b0;
				rounds <= key_256 ? aes_pkg::rounds_256 : aes_pkg::rounds_128;
			end else if (keys_done) begin
				key_ready <= 1'b1;
			end
			if (start_ok) begin
				busy <= 1'b1;
				round <= 4'd1;
			end else if (busy) begin
				if (final_round) begin
					busy <= 1'b0;
					round <= '0;
					block_done <= 1'b1;
				end else begin
					round <= round + 4'd1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start_ok)
			state <= block_in ^ key_rd_data;
		else if (busy)
			state <= next_state;
		if (busy && final_round)
			block_out <= next_state;
	end

	// A finished block must have used a complete key schedule.
	assert property (@(posedge clk) disable iff (reset)
		block_done |-> key_ready);

endmodule

// File: aes_core.sv
module aes_core (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           key_load,
	input  logic                           key_256,
	input  logic [aes_pkg::key_bits-1:0]   key,
	input  logic                           block_start,
	input  logic [aes_pkg::block_bits-1:0] block_in,
	output logic                           key_ready,
	output logic                           block_done,
	output logic [aes_pkg::block_bits-1:0] block_out
);

	logic                                key_wr_en;
	logic [aes_pkg::round_addr_bits-1:0] key_wr_addr;
	logic [aes_pkg::block_bits-1:0]      key_wr_data;
	logic                                keys_done;
	logic [aes_pkg::round_addr_bits-1:0] key_rd_addr;
	logic [aes_pkg::block_bits-1:0]      key_rd_data;

	round_key u_round_key (
		.clk         (clk),
		.reset       (reset),
		.key_load    (key_load),
		.key_256     (key_256),
		.key         (key),
		.key_wr_en   (key_wr_en),
		.key_wr_addr (key_wr_addr),
		.key_wr_data (key_wr_data),
		.keys_done   (keys_done)
	);

	round_key_mem u_round_key_mem (
		.clk     (clk),
		.wr_en   (key_wr_en),
		.wr_addr (key_wr_addr),
		.wr_data (key_wr_data),
		.rd_addr (key_rd_addr),
		.rd_data (key_rd_data)
	);

	aes_cipher u_aes_cipher (
		.clk         (clk),
		.reset       (reset),
		.key_load    (key_load),
		.key_256     (key_256),
		.keys_done   (keys_done),
		.block_start (block_start),
		.block_in    (block_in),
		.key_rd_data (key_rd_data),
		.key_rd_addr (key_rd_addr),
		.key_ready   (key_ready),
		.block_done  (block_done),
		.block_out   (block_out)
	);

endmodule

// File: tb_aes_core.sv
module tb_aes_core;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int timeout_cycles = 200;

	logic         clk;
	logic         reset;
	logic         key_load;
	logic         key_256;
	logic [255:0] key;
	logic         block_start;
	logic [127:0] block_in;
	logic         key_ready;
	logic         block_done;
	logic [127:0] block_out;

	logic [127:0] exp_q [$];
	int           due_q [$];
	int           cycle = 0;
	int           checks = 0;
	int           errors = 0;
	int           seed = 32'hcb2890af;
	logic         cur_mode;

	aes_core uut (
		.clk         (clk),
		.reset       (reset),
		.key_load    (key_load),
		.key_256     (key_256),
		.key         (key),
		.block_start (block_start),
		.block_in    (block_in),
		.key_ready   (key_ready),
		.block_done  (block_done),
		.block_out   (block_out)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	always @(posedge clk) cycle <= cycle + 1;

	function automatic logic [31:0] substitute_word(input logic [31:0] w);
		logic [31:0] r;
		for (int i = 0; i < 4; i++)
			r[8*i +: 8] = aes_pkg::sbox(w[8*i +: 8]);
		return r;
	endfunction

	function automatic logic [127:0] substitute_bytes(input logic [127:0] s);
		logic [127:0] r;
		for (int i = 0; i < 16; i++)
			r[8*i +: 8] = aes_pkg::sbox(s[8*i +: 8]);
		return r;
	endfunction

	// FIPS-197 word order, with the first key word in key[127:96].
	function automatic logic [127:0] aes_encrypt(input logic [255:0] k, input logic m,
		input logic [127:0] b);
		logic [31:0]  w [60];
		logic [31:0]  t;
		logic [127:0] s;
		logic [7:0]   rc;
		int           nk;
		int           nr;
		nk = m ? 8 : 4;
		nr = m ? 14 : 10;
		for (int i = 0; i < 4; i++) begin
			w[i] = k[127 - 32*i -: 32];
			w[i + 4] = k[255 - 32*i -: 32];
		end
		rc = 8'h01;
		for (int i = nk; i < 4 * (nr + 1); i++) begin
			t = w[i - 1];
			if (i % nk == 0) begin
				t = substitute_word({t[23:0], t[31:24]}) ^ {rc, 24'h000000};
				rc = {rc[6:0], 1'b0} ^ (rc[7] ? 8'h1b : 8'h00);
			end else if (nk == 8 && i % nk == 4) begin
				t = substitute_word(t);
			end
			w[i] = w[i - nk] ^ t;
		end
		s = b ^ {w[0], w[1], w[2], w[3]};
		for (int r = 1; r <= nr; r++) begin
			s = aes_pkg::shift_rows(substitute_bytes(s));
			if (r != nr)
				s = aes_pkg::mix_columns(s);
			s = s ^ {w[4*r], w[4*r + 1], w[4*r + 2], w[4*r + 3]};
		end
		return s;
	endfunction

	always @(negedge clk) begin
		logic [127:0] expected;
		int           due;
		if (!reset && block_done === 1'b1) begin
			if (exp_q.size() == 0) begin
				$display("Unexpected block_done with no block in flight at cycle %0d", cycle);
				errors++;
			end else begin
				expected = exp_q.pop_front();
				due = due_q.pop_front();
				checks++;
				if (block_out !== expected) begin
					$display("Fail block_out expected %h got %h", expected, block_out);
					errors++;
				end
				if (cycle != due) begin
					$display("Fail block_done cycle expected %h got %h", due, cycle);
					errors++;
				end
			end
		end
	end

	task automatic load_key(input logic [255:0] k, input logic m, input logic early_start);
		int load_cycle;
		int t;
		@(negedge clk);
		key = k;
		key_256 = m;
		key_load = 1'b1;
		load_cycle = cycle;
		cur_mode = m;
		@(negedge clk);
		key_load = 1'b0;
		block_start = early_start;
		t = 0;
		while (key_ready !== 1'b1 && t < timeout_cycles) begin
			@(negedge clk);
			block_start = 1'b0;
			t++;
		end
		block_start = 1'b0;
		if (key_ready !== 1'b1) begin
			$display("Timeout waiting for key_ready after a key load");
			errors++;
		end else begin
			checks++;
			// Expansion takes N+2 edges counted from the edge that samples key_load.
			if (cycle != load_cycle + (m ? 14 : 10) + 3) begin
				$display("Fail key_ready cycle expected %h got %h",
					load_cycle + (m ? 14 : 10) + 3, cycle);
				errors++;
			end
		end
	endtask

	task automatic start_block(input logic [127:0] b, input logic [127:0] expected);
		@(negedge clk);
		block_in = b;
		block_start = 1'b1;
		exp_q.push_back(expected);
		due_q.push_back(cycle + 1 + (cur_mode ? 14 : 10));
		@(negedge clk);
		block_start = 1'b0;
	endtask

	task automatic wait_idle();
		int t;
		t = 0;
		while (exp_q.size() != 0 && t < timeout_cycles) begin
			@(negedge clk);
			t++;
		end
		if (exp_q.size() != 0) begin
			$display("Timeout waiting for block_done");
			errors++;
			exp_q.delete();
			due_q.delete();
		end
		// A quiet stretch lets any stray block_done show up.
		repeat (20) @(negedge clk);
	endtask

	task automatic report_test(input string name, input int errors_before);
		if (errors == errors_before)
			$display("Test %s ok", name);
		else
			$display("Test %s failed with %0d errors", name, errors - errors_before);
	endtask

	task automatic run_random();
		logic [255:0] k;
		logic [127:0] b;
		for (int g = 0; g < 4; g++) begin
			for (int j = 0; j < 8; j++)
				k[32*j +: 32] = $random(seed);
			load_key(k, g[0], 1'b0);
			for (int n = 0; n < 5; n++) begin
				for (int j = 0; j < 4; j++)
					b[32*j +: 32] = $random(seed);
				start_block(b, aes_encrypt(k, g[0], b));
				wait_idle();
			end
		end
	endtask

	initial begin
		logic [255:0] k128;
		logic [255:0] k256;
		logic [127:0] pt;
		logic [127:0] ct128;
		logic [127:0] ct256;
		int           errs;
		k128 = {128'h0, 128'h000102030405060708090a0b0c0d0e0f};
		k256 = {128'h101112131415161718191a1b1c1d1e1f, 128'h000102030405060708090a0b0c0d0e0f};
		pt = 128'h00112233445566778899aabbccddeeff;
		ct128 = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
		ct256 = 128'h8ea2b7ca516745bfeafc49904b496089;
		reset = 1'b1;
		key_load = 1'b0;
		key_256 = 1'b0;
		key = '0;
		block_start = 1'b0;
		block_in = '0;
		cur_mode = 1'b0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		errs = errors;
		checks++;
		if (aes_encrypt(k128, 1'b0, pt) !== ct128) begin
			$display("Fail aes_encrypt expected %h got %h", ct128, aes_encrypt(k128, 1'b0, pt));
			errors++;
		end
		load_key(k128, 1'b0, 1'b0);
		start_block(pt, ct128);
		wait_idle();
		report_test("aes128 known vector", errs);

		errs = errors;
		checks++;
		if (aes_encrypt(k256, 1'b1, pt) !== ct256) begin
			$display("Fail aes_encrypt expected %h got %h", ct256, aes_encrypt(k256, 1'b1, pt));
			errors++;
		end
		load_key(k256, 1'b1, 1'b0);
		start_block(pt, ct256);
		wait_idle();
		report_test("aes256 known vector", errs);

		errs = errors;
		load_key(k128, 1'b0, 1'b0);
		load_key(k256, 1'b1, 1'b0);
		report_test("key_ready timing", errs);

		errs = errors;
		load_key(k128, 1'b0, 1'b1);
		wait_idle();
		start_block(pt, ct128);
		@(negedge clk);
		block_in = ~pt;
		block_start = 1'b1;
		@(negedge clk);
		block_start = 1'b0;
		wait_idle();
		report_test("ignored starts", errs);

		errs = errors;
		run_random();
		report_test("random traffic", errs);

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// File: list.f
aes_pkg.sv
round_key_mem.sv
round_key.sv
aes_cipher.sv
aes_core.sv
tb_aes_core.sv

// File: Makefile
TOP = tb_aes_core
BUILD = obj_dir

all: run

run:
	verilator --binary --timing --assert --top-module $(TOP) -f list.f -Mdir $(BUILD) -o sim
	./$(BUILD)/sim | tee sim.log
	grep -q "Regression passed" sim.log

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f list.f

clean:
	rm -rf $(BUILD) sim.log

.PHONY: all run lint clean
